// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= eeprom_ctrl_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "Test failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Test failed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/eeprom_ctrl_assertions.sv ====
module eeprom_ctrl_assertions
    import eeprom_pkg::*;
(
    input logic     CLK,
    input logic     RESET,
    input logic     req_ready,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input logic [7:0] rsp_rdata,
    input logic     rsp_nack,
    input logic     scl,
    input logic     sda_low,
    input bit_cmd_t cmd_op
);
    timeunit 1ns;
    timeprecision 100ps;

    no_req_during_rsp: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |-> !req_ready)
        else $error("req_ready high while a response is pending");

    rsp_held: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_rdata) && $stable(rsp_nack))
        else $error("response changed before rsp_ready");

    // sda moves under high scl only for start and stop
    sda_fall_is_start: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $rose(sda_low) |-> cmd_op == CMD_START)
        else $error("sda fell with scl high outside a start");

    sda_rise_is_stop: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $fell(sda_low) |-> cmd_op == CMD_STOP)
        else $error("sda rose with scl high outside a stop");

    bus_idle_after_reset: assert property (@(posedge CLK)
        $fell(RESET) |-> scl && !sda_low)
        else $error("bus not idle after reset");
endmodule

// ==== bench/eeprom_ctrl_tb.sv ====
module eeprom_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_FIXED = 14;
    localparam int N_ROWS  = N_FIXED + 30;
    localparam longint LIMIT_NS = 64'(N_ROWS) * 60 * 16 * 4 * 2;

    logic        CLK;
    logic        RESET;
    logic        req_valid;
    logic        req_write;
    logic [10:0] req_addr;
    logic [7:0]  req_wdata;
    logic        rsp_ready;
    logic        req_ready;
    logic        rsp_valid;
    logic [7:0]  rsp_rdata;
    logic        rsp_nack;
    logic        scl;
    logic        sda_low;
    logic        sda_rel;
    logic        sda;
    logic        busy;

    // stimulus table, one row per test
    logic        row_write [N_ROWS];
    logic [10:0] row_addr  [N_ROWS];
    logic [7:0]  row_data  [N_ROWS];
    logic        row_busy  [N_ROWS];
    int          row_hold  [N_ROWS];

    logic [7:0]  shadow [2048];
    logic [31:0] lfsr_state;
    int          n_fail;

    assign sda = !sda_low && sda_rel;  // open drain wire

    tb_clock_gen u_clk (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl_top #(.CLK_DIV(4)) UUT
    (
        .CLK(CLK), .RESET(RESET), .req_valid(req_valid), .req_write(req_write),
        .req_addr(req_addr), .req_wdata(req_wdata), .rsp_ready(rsp_ready),
        .sda_in(sda), .req_ready(req_ready), .rsp_valid(rsp_valid),
        .rsp_rdata(rsp_rdata), .rsp_nack(rsp_nack), .scl(scl), .sda_low(sda_low)
    );

    eeprom_model u_eeprom
    (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda), .busy(busy), .sda_rel(sda_rel)
    );

    bind eeprom_ctrl_top eeprom_ctrl_assertions u_assert
    (
        .CLK(CLK), .RESET(RESET), .req_ready(req_ready), .rsp_valid(rsp_valid),
        .rsp_ready(rsp_ready), .rsp_rdata(rsp_rdata), .rsp_nack(rsp_nack),
        .scl(scl), .sda_low(sda_low), .cmd_op(cmd_op)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h80200003 : lfsr_state >> 1;
        end
        return v;
    endfunction

    task automatic set_row(input int i, input logic w, input logic [10:0] a,
                           input logic [7:0] d, input logic b, input int h);
        row_write[i] = w;
        row_addr[i]  = a;
        row_data[i]  = d;
        row_busy[i]  = b;
        row_hold[i]  = h;
    endtask

    task automatic build_table();
        logic [31:0] r;
        set_row(0, 1, 11'h123, 8'h5a, 0, 0);
        set_row(1, 0, 11'h123, 8'h00, 0, 0);
        set_row(2, 0, 11'h456, 8'h00, 0, 0);   // never written
        set_row(3, 1, 11'h234, 8'h11, 0, 0);
        set_row(4, 1, 11'h234, 8'h99, 1, 0);   // slave busy
        set_row(5, 0, 11'h234, 8'h00, 0, 0);
        set_row(6, 1, 11'h0ab, 8'h01, 0, 0);
        set_row(7, 1, 11'h1ab, 8'h02, 0, 0);
        set_row(8, 1, 11'h7ab, 8'h07, 0, 0);
        set_row(9, 0, 11'h0ab, 8'h00, 0, 0);
        set_row(10, 0, 11'h1ab, 8'h00, 0, 3);
        set_row(11, 0, 11'h7ab, 8'h00, 0, 20);
        set_row(12, 1, 11'h300, 8'hc3, 0, 35);
        set_row(13, 0, 11'h123, 8'h00, 1, 0);
        for (int i = N_FIXED; i < N_ROWS; i++)
        begin
            r = draw_bits(16);
            // small address pool so reads hit earlier writes
            set_row(i, r[15], {r[14:12], 6'b010000, r[11:10]}, r[9:2], 0, int'(r[1:0]));
        end
    endtask

    task automatic run_row(input int i);
        logic [7:0] exp_rdata;
        logic       exp_nack;
        logic [7:0] got_rdata;
        logic       got_nack;
        logic       ok;
        ok = 1'b1;
        exp_nack  = row_busy[i];
        exp_rdata = (row_busy[i] || row_write[i]) ? 8'h00 : shadow[row_addr[i]];
        if (row_write[i] && !row_busy[i])
            shadow[row_addr[i]] = row_data[i];

        @(posedge CLK);
        req_valid <= 1'b1;
        req_write <= row_write[i];
        req_addr  <= row_addr[i];
        req_wdata <= row_data[i];
        busy      <= row_busy[i];
        do @(posedge CLK); while (!req_ready);
        req_valid <= 1'b0;

        do @(posedge CLK); while (!rsp_valid);
        got_rdata = rsp_rdata;
        got_nack  = rsp_nack;
        assert (got_rdata == exp_rdata && got_nack == exp_nack)
        else
        begin
            $display("mismatch at %0t: row %0d rdata %h nack %b, expected %h %b",
                     $time, i, got_rdata, got_nack, exp_rdata, exp_nack);
            ok = 1'b0;
        end
        for (int c = 0; c < row_hold[i]; c++)
        begin
            @(posedge CLK);
            assert (rsp_valid && rsp_rdata == got_rdata && rsp_nack == got_nack && !req_ready)
            else
            begin
                $display("mismatch at %0t: row %0d response moved under back-pressure",
                         $time, i);
                ok = 1'b0;
            end
        end
        rsp_ready <= 1'b1;
        @(posedge CLK);
        rsp_ready <= 1'b0;
        busy      <= 1'b0;
        if (!ok)
            n_fail++;
        $display("row %0d %s addr %h data %h: %s", i, row_write[i] ? "write" : "read ",
                 row_addr[i], got_rdata, ok ? "ok" : "FAIL");
    endtask

    initial
    begin
        req_valid  = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        rsp_ready  = 1'b0;
        busy       = 1'b0;
        n_fail     = 0;
        lfsr_state = 32'h1344a93d;
        for (int a = 0; a < 2048; a++)
            shadow[a] = 8'hff;
        build_table();
        @(negedge RESET);
        for (int i = 0; i < N_ROWS; i++)
            run_row(i);
        $display("%0d tests, %0d passed, %0d failed", N_ROWS, N_ROWS - n_fail, n_fail);
        if (n_fail == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("timeout: no response within %0d ns", LIMIT_NS);
        $display("Test failed");
        $finish;
    end
endmodule

// ==== bench/eeprom_model.sv ====
module eeprom_model
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic busy,      // forces nack on every byte
    output logic sda_rel    // low pulls the line down
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [2048];
    logic        active;
    logic        in_ack;
    logic        tx_mode;
    logic        rd_dir;
    logic        abort;
    logic        master_nack;
    logic [3:0]  bit_cnt;
    logic [1:0]  byte_idx;
    logic [7:0]  sreg;
    logic [7:0]  tx_byte;
    logic [10:0] ptr;
    logic        scl_q;
    logic        sda_q;
    logic        byte_ok;

    assign byte_ok = !busy && (byte_idx != 2'd0 || sreg[7:4] == 4'b1010);

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'hff;
    end

    // bus seen through clk samples, edges found against the previous sample
    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
        begin
            active  <= 1'b0;
            in_ack  <= 1'b0;
            tx_mode <= 1'b0;
            sda_rel <= 1'b1;
        end
        else if (scl && scl_q && sda_q && !sda)
        begin
            active   <= 1'b1;  // start or repeated start
            in_ack   <= 1'b0;
            tx_mode  <= 1'b0;
            abort    <= 1'b0;
            bit_cnt  <= 4'd0;
            byte_idx <= 2'd0;
            sda_rel  <= 1'b1;
        end
        else if (scl && scl_q && !sda_q && sda)
        begin
            active  <= 1'b0;  // stop
            sda_rel <= 1'b1;
        end
        else if (active && scl && !scl_q)
        begin
            if (!in_ack)
            begin
                bit_cnt <= bit_cnt + 4'd1;
                if (!tx_mode)
                    sreg <= {sreg[6:0], sda};
            end
            else if (tx_mode)
                master_nack <= sda;
        end
        else if (active && !scl && scl_q)
        begin
            if (in_ack)
            begin
                in_ack  <= 1'b0;
                bit_cnt <= 4'd0;
                if (abort || (tx_mode && master_nack))
                begin
                    active  <= 1'b0;
                    sda_rel <= 1'b1;
                end
                else if (rd_dir)
                begin
                    tx_mode <= 1'b1;
                    tx_byte <= mem[ptr];
                    sda_rel <= mem[ptr][7];
                    ptr     <= ptr + 11'd1;
                end
                else
                    sda_rel <= 1'b1;
            end
            else if (bit_cnt == 4'd8)
            begin
                in_ack <= 1'b1;
                if (tx_mode)
                    sda_rel <= 1'b1;  // master drives its ack
                else
                begin
                    sda_rel  <= !byte_ok;
                    abort    <= !byte_ok;
                    byte_idx <= byte_idx + 2'd1;
                    if (byte_ok && byte_idx == 2'd0)
                    begin
                        rd_dir     <= sreg[0];
                        ptr[10:8]  <= sreg[3:1];  // block select
                    end
                    else if (byte_ok && byte_idx == 2'd1)
                        ptr[7:0] <= sreg;
                    else if (byte_ok)
                        mem[ptr] <= sreg;
                end
            end
            else if (tx_mode)
                sda_rel <= tx_byte[3'(7 - bit_cnt)];
        end
    end
endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen
(
    output logic CLK,
    output logic RESET
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;  // 4 ns period
    end

    initial
    begin
        RESET = 1'b1;
        repeat (16) @(posedge CLK);
        RESET <= 1'b0;
    end
endmodule

// ==== design/eeprom_ctrl_top.sv ====
module eeprom_ctrl_top
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4  // clk cycles per quarter scl period
)
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic [10:0] req_addr,
    input  logic [7:0]  req_wdata,
    input  logic        rsp_ready,
    input  logic        sda_in,
    output logic        req_ready,
    output logic        rsp_valid,
    output logic [7:0]  rsp_rdata,
    output logic        rsp_nack,
    output logic        scl,
    output logic        sda_low
);

    logic       cmd_valid;
    logic       cmd_ready;
    bit_cmd_t   cmd_op;
    logic [7:0] cmd_byte;
    logic       cmd_last;
    logic       done;
    logic [7:0] rx_byte;
    logic       ack_in;

    eeprom_sequencer u_seq
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .rsp_ready (rsp_ready),
        .cmd_ready (cmd_ready),
        .done      (done),
        .rx_byte   (rx_byte),
        .ack_in    (ack_in),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_nack  (rsp_nack),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_byte  (cmd_byte),
        .cmd_last  (cmd_last)
    );

    i2c_bit_engine #(.CLK_DIV(CLK_DIV)) u_engine
    (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_byte  (cmd_byte),
        .cmd_last  (cmd_last),
        .sda_in    (sda_in),
        .cmd_ready (cmd_ready),
        .done      (done),
        .rx_byte   (rx_byte),
        .ack_in    (ack_in),
        .scl       (scl),
        .sda_low   (sda_low)
    );

endmodule

// ==== design/eeprom_pkg.sv ====
package eeprom_pkg;

    // operations the bit engine understands
    // a start issued with SCL still high after a byte is a repeated start
    typedef enum logic [1:0]
    {
        CMD_START = 2'd0,
        CMD_STOP  = 2'd1,
        CMD_WRITE = 2'd2, // byte out, ack sampled
        CMD_READ  = 2'd3  // byte in, ack or nack driven
    } bit_cmd_t;

    // transaction sequencer states
    typedef enum logic [3:0]
    {
        ST_IDLE    = 4'd0,
        ST_START   = 4'd1,
        ST_CTRL_W  = 4'd2, // control byte, write direction
        ST_ADDR    = 4'd3, // low eight address bits
        ST_DATA    = 4'd4,
        ST_RESTART = 4'd5,
        ST_CTRL_R  = 4'd6, // control byte, read direction
        ST_READ    = 4'd7,
        ST_STOP    = 4'd8,
        ST_RESP    = 4'd9  // response held for the host
    } seq_state_t;

    // 24C16 style device code, sits above a[10:8] and the r/w bit
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

// ==== design/eeprom_sequencer.sv ====
module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        req_valid,
    input  logic        req_write,
    input  logic [10:0] req_addr,
    input  logic [7:0]  req_wdata,
    input  logic        rsp_ready,
    input  logic        cmd_ready,
    input  logic        done,
    input  logic [7:0]  rx_byte,
    input  logic        ack_in,
    output logic        req_ready,
    output logic        rsp_valid,
    output logic [7:0]  rsp_rdata,
    output logic        rsp_nack,
    output logic        cmd_valid,
    output bit_cmd_t    cmd_op,
    output logic [7:0]  cmd_byte,
    output logic        cmd_last
);

    seq_state_t  state;
    logic        sent;      // command handed to the engine, waiting for done
    logic        write_q;
    logic        nack_q;
    logic [7:0]  rdata_q;
    logic [10:0] addr_q;
    logic [7:0]  wdata_q;
    logic        slave_nack;

    assign req_ready  = (state == ST_IDLE);
    assign rsp_valid  = (state == ST_RESP);
    assign rsp_rdata  = rdata_q;
    assign rsp_nack   = nack_q;
    assign slave_nack = done && ack_in;

    assign cmd_valid = (state != ST_IDLE) && (state != ST_RESP) && !sent;
    assign cmd_last  = (state == ST_READ);

    always_comb
    begin
        case (state)
            ST_START, ST_RESTART: cmd_op = CMD_START;
            ST_STOP:              cmd_op = CMD_STOP;
            ST_READ:              cmd_op = CMD_READ;
            default:              cmd_op = CMD_WRITE;
        endcase
    end

    // control byte carries a[10:8] as the block select
    always_comb
    begin
        case (state)
            ST_CTRL_W: cmd_byte = {DEVICE_CODE, addr_q[10:8], 1'b0};
            ST_CTRL_R: cmd_byte = {DEVICE_CODE, addr_q[10:8], 1'b1};
            ST_ADDR:   cmd_byte = addr_q[7:0];
            ST_DATA:   cmd_byte = wdata_q;
            default:   cmd_byte = 8'h00;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (req_valid && req_ready)
        begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= ST_IDLE;
            sent    <= 1'b0;
            write_q <= 1'b0;
            nack_q  <= 1'b0;
            rdata_q <= 8'h00;
        end
        else
        begin
            if (done)
            begin
                sent <= 1'b0;
            end
            else if (cmd_valid && cmd_ready)
            begin
                sent <= 1'b1;
            end

            case (state)
                ST_IDLE:
                begin
                    if (req_valid)
                    begin
                        write_q <= req_write;
                        nack_q  <= 1'b0;
                        rdata_q <= 8'h00;
                        state   <= ST_START;
                    end
                end
                ST_START:
                begin
                    if (done)
                    begin
                        state <= ST_CTRL_W;
                    end
                end
                ST_CTRL_W, ST_ADDR, ST_DATA, ST_CTRL_R:
                begin
                    if (slave_nack)
                    begin
                        nack_q <= 1'b1;  // abort, finish with stop
                        state  <= ST_STOP;
                    end
                    else if (done)
                    begin
                        case (state)
                            ST_CTRL_W: state <= ST_ADDR;
                            ST_ADDR:   state <= write_q ? ST_DATA : ST_RESTART;
                            ST_CTRL_R: state <= ST_READ;
                            default:   state <= ST_STOP;
                        endcase
                    end
                end
                ST_RESTART:
                begin
                    if (done)
                    begin
                        state <= ST_CTRL_R;
                    end
                end
                ST_READ:
                begin
                    if (done)
                    begin
                        rdata_q <= rx_byte;
                        state   <= ST_STOP;
                    end
                end
                ST_STOP:
                begin
                    if (done)
                    begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP:
                begin
                    if (rsp_ready)
                    begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== design/i2c_bit_engine.sv ====
module i2c_bit_engine
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_valid,
    input  bit_cmd_t   cmd_op,
    input  logic [7:0] cmd_byte,
    input  logic       cmd_last,
    input  logic       sda_in,
    output logic       cmd_ready,
    output logic       done,
    output logic [7:0] rx_byte,
    output logic       ack_in,
    output logic       scl,
    output logic       sda_low
);

    localparam int QW = $clog2(CLK_DIV);
    localparam logic [QW-1:0] Q_LAST = QW'(CLK_DIV - 1);

    logic          busy;
    bit_cmd_t      op_q;
    logic          last_q;   // nack on the ninth bit of a read
    logic [QW-1:0] q_cnt;    // clk cycles inside a quarter
    logic [1:0]    phase;    // quarter of the scl period
    logic [3:0]    bit_cnt;
    logic [7:0]    sreg;

    logic          accept;
    logic          q_end;
    logic          bit_start;
    logic          sample;
    logic          byte_op;
    logic          last_bit;
    logic          ack_bit;

    assign accept    = !busy && cmd_valid;
    assign q_end     = busy && (q_cnt == Q_LAST);
    assign bit_start = busy && (phase == 2'd0) && (q_cnt == '0);  // one clk after scl falls
    assign sample    = busy && (phase == 2'd2) && (q_cnt == '0);  // first clk of scl high
    assign byte_op   = (op_q == CMD_WRITE) || (op_q == CMD_READ);
    assign ack_bit   = (bit_cnt == 4'd8);
    assign last_bit  = byte_op ? ack_bit : (bit_cnt == 4'd0);

    assign cmd_ready = !busy;
    assign rx_byte   = sreg;

    // quarter, phase and bit counters
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_q    <= CMD_START;
            last_q  <= 1'b0;
            q_cnt   <= '0;
            phase   <= 2'd0;
            bit_cnt <= 4'd0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (accept)
            begin
                busy    <= 1'b1;
                op_q    <= cmd_op;
                last_q  <= cmd_last;
                q_cnt   <= '0;
                phase   <= 2'd0;
                bit_cnt <= 4'd0;
            end
            else if (q_end)
            begin
                q_cnt <= '0;
                phase <= phase + 2'd1;  // wraps 3 -> 0
                if (phase == 2'd3)
                begin
                    if (last_bit)
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end
            else if (busy)
            begin
                q_cnt <= q_cnt + 1'b1;
            end
        end
    end

    // scl: low in quarters 0 and 1, high in 2 and 3, parked high when idle
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl <= 1'b1;
        end
        else if (accept)
        begin
            scl <= 1'b0;
        end
        else if (q_end)
        begin
            if (phase == 2'd1)
            begin
                scl <= 1'b1;
            end
            else if (phase == 2'd3 && !last_bit)
            begin
                scl <= 1'b0;
            end
        end
    end

    // sda pull-low and ack sampling
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            sda_low <= 1'b0;
            ack_in  <= 1'b0;
        end
        else
        begin
            if (bit_start)
            begin
                case (op_q)
                    CMD_START: sda_low <= 1'b0;  // release, line high before the fall
                    CMD_STOP:  sda_low <= 1'b1;
                    CMD_WRITE: sda_low <= ack_bit ? 1'b0 : ~sreg[7];
                    CMD_READ:  sda_low <= ack_bit ? ~last_q : 1'b0;
                    default:   sda_low <= 1'b0;
                endcase
            end
            else if (q_end && phase == 2'd2)
            begin
                // middle of scl high
                if (op_q == CMD_START)
                begin
                    sda_low <= 1'b1;
                end
                else if (op_q == CMD_STOP)
                begin
                    sda_low <= 1'b0;
                end
            end

            if (sample && byte_op && ack_bit)
            begin
                ack_in <= sda_in;  // low means ack
            end
        end
    end

    // shared shift register, msb first both ways
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            sreg <= cmd_byte;
        end
        else if (bit_start && op_q == CMD_WRITE && !ack_bit)
        begin
            sreg <= {sreg[6:0], 1'b0};
        end
        else if (sample && op_q == CMD_READ && !ack_bit)
        begin
            sreg <= {sreg[6:0], sda_in};
        end
    end

endmodule

// ==== sources.f ====
design/eeprom_pkg.sv
design/i2c_bit_engine.sv
design/eeprom_sequencer.sv
design/eeprom_ctrl_top.sv
bench/tb_clock_gen.sv
bench/eeprom_model.sv
bench/eeprom_ctrl_assertions.sv
bench/eeprom_ctrl_tb.sv
